/* sound_top.f */
src/sound_pkg.sv
src/cpu_bus_if.sv
src/sound_decode.sv
src/psg.sv
src/adpcm_decoder.sv
src/pcm_player.sv
src/sound_top.sv
test/sound_asserts.sv
test/sound_tb.sv

/* test/sound_tb.sv */
// sound board testbench
module sound_tb;

    // reset, latch, ram, psg, nmi, two pcm rounds
    localparam int planned_cycles = 10 + 100 + 800 + 600 + 20 + 1040;
    localparam int timeout_cycles = 4 * planned_cycles;
    localparam int vclk_count     = 40;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  cen_psg = 1'b0;
    logic                  cen_pcm = 1'b0;
    logic                  m2s_set;
    logic [7:0]            m2s;
    logic [7:0]            s2m;
    logic                  nmi_n;
    logic [15:0]           bus_addr;
    logic [7:0]            bus_wdata;
    logic                  bus_mreq;
    logic                  bus_iorq;
    logic                  bus_wr;
    logic                  bus_rd;
    logic [7:0]            bus_rdata;
    sound_pkg::pcm_addr_t  pcm_addr;
    logic [7:0]            pcm_data = 8'h00;
    logic                  pcm_ok;
    sound_pkg::psg_level_t psg0;
    sound_pkg::psg_level_t psg1;
    sound_pkg::sample_t    pcm;
    logic [7:0]            st_dout;

    logic [31:0] seed = 32'hdbce;
    logic [1:0]  cen_cnt = 2'd0;
    int          cycles = 0;
    logic [7:0]  rom [0:32767];
    logic [7:0]  ram_model [0:2047];
    logic [7:0]  psg_regs [0:1][0:15];
    logic        m_en;
    logic [3:0]  m_gain;
    logic [14:0] m_start;
    logic [15:0] m_pos;  // {pcm_addr, nibble_sel}
    int          m_sig;
    int          m_idx;
    int          pulses;

    sound_top dut_i (.*);

    initial begin
        forever #4 clk = ~clk;
    end

    // cen strobes and the sample ROM
    always @(negedge clk) begin
        cen_psg  <= ~cen_psg;
        cen_cnt  <= (cen_cnt == 2'd2) ? 2'd0 : cen_cnt + 2'd1;
        cen_pcm  <= (cen_cnt == 2'd2);
        pcm_data <= rom[pcm_addr];
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == timeout_cycles) begin
            report_fail($sformatf("timeout, tests still running after %0d cycles", cycles));
        end
    end

    function logic [31:0] rand32();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {8'd0, seed[31:8]};  // low LCG bits are weak
    endfunction

    task automatic report_fail(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) report_fail($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) report_fail($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_level(input string name, input sound_pkg::psg_level_t got,
                               input sound_pkg::psg_level_t exp);
        if (got !== exp) report_fail($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_sample(input string name, input sound_pkg::sample_t got,
                                input sound_pkg::sample_t exp);
        if (got !== exp) report_fail($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_addr(input string name, input sound_pkg::pcm_addr_t got,
                              input sound_pkg::pcm_addr_t exp);
        if (got !== exp) report_fail($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic level_within(input string name, input sound_pkg::psg_level_t got, input int limit);
        if ($isunknown(got) || got > limit) begin
            report_fail($sformatf("[ERROR] %s: got %h, above the limit %h", name, got, limit));
        end
    endtask

    // one strobe cycle, data valid at the following falling edge
    task automatic bus_cycle(input logic [15:0] addr, input logic [7:0] data, input bit io,
                             input bit wr);
        @(negedge clk);
        bus_addr  = addr;
        bus_wdata = data;
        bus_mreq  = !io;
        bus_iorq  = io;
        bus_wr    = wr;
        bus_rd    = !wr;
        @(negedge clk);
        bus_mreq = 1'b0;
        bus_iorq = 1'b0;
        bus_wr   = 1'b0;
        bus_rd   = 1'b0;
    endtask

    task automatic mem_write(input logic [15:0] addr, input logic [7:0] data);
        bus_cycle(addr, data, 1'b0, 1'b1);
    endtask

    task automatic mem_read(input logic [15:0] addr, output logic [7:0] data);
        bus_cycle(addr, 8'h00, 1'b0, 1'b0);
        data = bus_rdata;
    endtask

    task automatic io_write(input bit chip, input logic [3:0] regno, input logic [7:0] data);
        bus_cycle({14'd0, chip, 1'b1}, {4'd0, regno}, 1'b1, 1'b1);
        bus_cycle({14'd0, chip, 1'b0}, data, 1'b1, 1'b1);
    endtask

    task automatic io_read(input bit chip, input logic [3:0] regno, output logic [7:0] data);
        bus_cycle({14'd0, chip, 1'b1}, {4'd0, regno}, 1'b1, 1'b1);
        bus_cycle({14'd0, chip, 1'b0}, 8'h00, 1'b1, 1'b0);
        data = bus_rdata;
    endtask

    task automatic ctl_write(input sound_pkg::ctl_reg_e ctl, input logic [7:0] data);
        logic [31:0] r;
        r = rand32();
        mem_write({2'(sound_pkg::region_ctl), r[13:2], 2'(ctl)}, data);
        case (ctl)
            sound_pkg::ctl_pcm_set: m_pos = {m_start, 1'b0};
            sound_pkg::ctl_pcm_ctl: m_en = data[0];
            sound_pkg::ctl_gain:    m_gain = data[3:0];
            default: ;
        endcase
        if (!m_en) begin
            m_pos[0] = 1'b0;  // decoder and nibble_sel held clear
            m_sig    = 0;
            m_idx    = 0;
            pulses   = 0;
        end
        check_byte("st_dout", st_dout, {m_en, 3'b000, m_gain});
    endtask

    // cen_pcm still shows the cycle that just ended
    task automatic play_step(output bit fired);
        @(negedge clk);
        fired = 1'b0;
        if (m_en && cen_pcm) begin
            pulses++;
            if (pulses == sound_pkg::pcm_div) begin
                pulses = 0;
                fired  = 1'b1;
            end
        end
    endtask

    function automatic logic [3:0] rom_nibble(input logic [15:0] pos);
        logic [7:0] b;
        b = rom[pos[15:1]];
        return pos[0] ? b[3:0] : b[7:4];
    endfunction

    task automatic predict_sample(input logic [3:0] nib);
        int step;
        int diff;
        step = sound_pkg::adpcm_step[m_idx];
        diff = step / 8;
        if (nib[2]) diff += step;
        if (nib[1]) diff += step / 2;
        if (nib[0]) diff += step / 4;
        m_sig = nib[3] ? m_sig - diff : m_sig + diff;
        if (m_sig > 2047) m_sig = 2047;
        if (m_sig < -2048) m_sig = -2048;
        m_idx = m_idx + sound_pkg::adpcm_index_delta[nib[2:0]];
        if (m_idx < 0) m_idx = 0;
        if (m_idx > 48) m_idx = 48;
    endtask

    function automatic sound_pkg::sample_t gain_model(input int sig, input logic [3:0] g);
        int prod;
        prod = sig * (int'(g) + 1);
        return sound_pkg::sample_t'(prod >>> 4);
    endfunction

    function automatic int level_limit(input int chip);
        int sum;
        sum = 0;
        for (int ch = 0; ch < 3; ch++) begin
            if (!psg_regs[chip][7][ch]) sum += psg_regs[chip][8 + ch][3:0] * 16;
        end
        return sum;
    endfunction

    // psg1 port pins mirror the play position
    task automatic check_ports();
        logic [7:0]  got;
        logic [14:0] pa;
        pa = m_pos[15:1];
        io_read(1'b1, 4'd14, got);
        check_byte("psg1 port a", got, {pa[7:1], 1'b1});
        io_read(1'b1, 4'd15, got);
        check_byte("psg1 port b", got, {1'b1, pa[14:8]});
    endtask

    task automatic test_latch();
        logic [7:0]  d;
        logic [7:0]  got;
        logic [31:0] r;
        r = rand32();
        mem_read({2'(sound_pkg::region_rom), r[13:0]}, got);
        check_byte("bus_rdata rom", got, 8'h00);
        repeat (20) begin
            m2s = 8'(rand32());
            r   = rand32();
            mem_read({2'(sound_pkg::region_latch), r[13:0]}, got);
            check_byte("bus_rdata m2s", got, m2s);
            d = 8'(rand32());
            r = rand32();
            mem_write({2'(sound_pkg::region_latch), r[13:0]}, d);
            check_byte("s2m", s2m, d);
        end
    endtask

    task automatic test_ram();
        logic [7:0]  got;
        logic [31:0] r;
        logic [10:0] a;
        logic [10:0] written [$];
        repeat (200) begin
            r = rand32();
            a = r[10:0];
            mem_write({2'(sound_pkg::region_ram), r[21:19], a}, 8'(r >> 11));
            ram_model[a] = 8'(r >> 11);
            written.push_back(a);
        end
        foreach (written[i]) begin
            r = rand32();  // another mirror
            mem_read({2'(sound_pkg::region_ram), r[2:0], written[i]}, got);
            check_byte($sformatf("bus_rdata ram[%h]", written[i]), got, ram_model[written[i]]);
        end
    endtask

    task automatic test_psg();
        logic [7:0] d;
        logic [7:0] got;
        int         limit0;
        int         limit1;
        for (int chip = 0; chip < 2; chip++) begin
            for (int n = 0; n < 14; n++) begin
                d = 8'(rand32());
                io_write(chip == 1, 4'(n), d);
                psg_regs[chip][n] = d;
            end
        end
        for (int chip = 0; chip < 2; chip++) begin
            for (int n = 0; n < 14; n++) begin
                io_read(chip == 1, 4'(n), got);
                check_byte($sformatf("psg%0d reg %0d", chip, n), got, psg_regs[chip][n]);
            end
        end
        check_ports();
        for (int chip = 0; chip < 2; chip++) begin
            for (int n = 8; n < 11; n++) begin
                io_write(chip == 1, 4'(n), 8'h00);
                psg_regs[chip][n] = 8'h00;
            end
        end
        repeat (50) begin
            @(negedge clk);
            check_level("psg0", psg0, '0);
            check_level("psg1", psg1, '0);
        end
        for (int chip = 0; chip < 2; chip++) begin
            for (int n = 0; n < 11; n++) begin
                if (n == 6) continue;
                d = 8'(rand32());
                if (n < 6) d = n[0] ? 8'h00 : {4'h0, d[3:0]};  // short periods
                io_write(chip == 1, 4'(n), d);
                psg_regs[chip][n] = d;
            end
        end
        limit0 = level_limit(0);
        limit1 = level_limit(1);
        repeat (200) begin
            @(negedge clk);
            level_within("psg0", psg0, limit0);
            level_within("psg1", psg1, limit1);
        end
    endtask

    task automatic test_nmi();
        check_flag("nmi_n", nmi_n, 1'b1);
        @(negedge clk);
        m2s_set = 1'b1;
        @(negedge clk);
        m2s_set = 1'b0;
        check_flag("nmi_n", nmi_n, 1'b0);
        ctl_write(sound_pkg::ctl_nmi_clr, 8'(rand32()));
        check_flag("nmi_n", nmi_n, 1'b1);
        // rise and clear together, rise wins
        @(negedge clk);
        m2s_set  = 1'b1;
        bus_addr = {2'(sound_pkg::region_ctl), 12'd0, 2'(sound_pkg::ctl_nmi_clr)};
        bus_mreq = 1'b1;
        bus_wr   = 1'b1;
        @(negedge clk);
        m2s_set  = 1'b0;
        bus_mreq = 1'b0;
        bus_wr   = 1'b0;
        check_flag("nmi_n", nmi_n, 1'b0);
        ctl_write(sound_pkg::ctl_nmi_clr, 8'h00);
        check_flag("nmi_n", nmi_n, 1'b1);
    endtask

    task automatic test_pcm();
        logic [7:0] lo;
        logic [7:0] hi;
        int         vclks;
        bit         fired;
        bit         pending;
        lo = 8'(rand32());
        hi = 8'(rand32());
        io_write(1'b0, 4'd14, lo);
        io_write(1'b0, 4'd15, hi);
        m_start = {hi[6:0], lo};
        ctl_write(sound_pkg::ctl_pcm_set, 8'(rand32()));
        ctl_write(sound_pkg::ctl_gain, 8'(rand32()));
        ctl_write(sound_pkg::ctl_pcm_ctl, 8'h01);
        vclks   = 0;
        pending = 1'b0;
        while (vclks < vclk_count || pending) begin
            play_step(fired);
            if (pending) begin
                check_sample("pcm", pcm, gain_model(m_sig, m_gain));
                if (vclks % 2 == 0) check_addr("pcm_addr", pcm_addr, m_pos[15:1]);
                pending = 1'b0;
            end
            if (fired) begin
                predict_sample(rom_nibble(m_pos));
                m_pos   = m_pos + 16'd1;
                vclks++;
                pending = 1'b1;  // pcm lands two edges later
            end
        end
        ctl_write(sound_pkg::ctl_pcm_ctl, 8'h00);
        repeat (2) @(negedge clk);
        check_sample("pcm", pcm, '0);
        check_ports();
    endtask

    initial begin
        rst_n     = 1'b0;
        m2s_set   = 1'b0;
        m2s       = 8'h00;
        bus_addr  = 16'h0000;
        bus_wdata = 8'h00;
        bus_mreq  = 1'b0;
        bus_iorq  = 1'b0;
        bus_wr    = 1'b0;
        bus_rd    = 1'b0;
        pcm_ok    = 1'b1;
        m_en      = 1'b0;
        m_gain    = 4'd0;
        m_start   = '0;
        m_pos     = 16'd0;
        m_sig     = 0;
        m_idx     = 0;
        pulses    = 0;
        for (int i = 0; i < 32768; i++) begin
            rom[i] = 8'(rand32());
        end
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_byte("s2m", s2m, 8'h00);
        check_flag("nmi_n", nmi_n, 1'b1);
        check_addr("pcm_addr", pcm_addr, '0);
        check_sample("pcm", pcm, '0);
        check_level("psg0", psg0, '0);
        check_level("psg1", psg1, '0);
        check_byte("st_dout", st_dout, 8'h00);

        test_latch();
        test_ram();
        test_psg();
        test_nmi();
        repeat (2) test_pcm();

        if (dut_i.decode_i.asserts_i.fail_count == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            report_fail($sformatf("%0d assertion failures in sound_decode",
                                  dut_i.decode_i.asserts_i.fail_count));
        end
    end

endmodule

/* test/sound_asserts.sv */
// sound decoder assertions
module sound_asserts (
    input logic clk,
    input logic rst_n,
    input logic psg0_cs,
    input logic psg1_cs,
    input logic mem_acc,
    input logic pcm_set,
    input logic m2s_set,
    input logic nmi_n
);

    int fail_count = 0;

    // at most one of the two chips and the memory per cycle
    a_cs_excl: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({psg0_cs, psg1_cs, mem_acc}))
        else begin
            $error("a PSG chip select overlaps another bus access");
            fail_count++;
        end

    // pcm_set comes from a single-cycle write strobe
    a_pcm_set_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        pcm_set |=> !pcm_set)
        else begin
            $error("pcm_set stayed high for more than one cycle");
            fail_count++;
        end

    a_nmi_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(nmi_n) |-> $past(m2s_set) && !$past(m2s_set, 2))
        else begin
            $error("nmi_n fell without a rise of m2s_set");
            fail_count++;
        end

endmodule

bind sound_decode sound_asserts asserts_i (.*);

/* src/sound_top.sv */
// sound board top level
module sound_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cen_psg,
    input  logic                  cen_pcm,
    input  logic                  m2s_set,
    input  logic [7:0]            m2s,
    output logic [7:0]            s2m,
    output logic                  nmi_n,
    input  logic [15:0]           bus_addr,
    input  logic [7:0]            bus_wdata,
    input  logic                  bus_mreq,
    input  logic                  bus_iorq,
    input  logic                  bus_wr,
    input  logic                  bus_rd,
    output logic [7:0]            bus_rdata,
    output sound_pkg::pcm_addr_t  pcm_addr,
    input  logic [7:0]            pcm_data,
    input  logic                  pcm_ok,
    output sound_pkg::psg_level_t psg0,
    output sound_pkg::psg_level_t psg1,
    output sound_pkg::sample_t    pcm,
    output logic [7:0]            st_dout
);

    logic               psg0_cs;
    logic               psg1_cs;
    logic [7:0]         psg0_rdata;
    logic [7:0]         psg1_rdata;
    logic               pcm_set;
    logic               pcm_en;
    logic [3:0]         gain;
    logic [7:0]         smp_lo;
    logic [7:0]         smp_hi;
    logic               vclk;
    logic [3:0]         nibble;
    sound_pkg::sample_t pcm_raw;

    cpu_bus_if bus_i ();

    assign bus_i.addr  = bus_addr;
    assign bus_i.wdata = bus_wdata;
    assign bus_i.mreq  = bus_mreq;
    assign bus_i.iorq  = bus_iorq;
    assign bus_i.wr    = bus_wr;
    assign bus_i.rd    = bus_rd;
    assign bus_rdata   = bus_i.rdata;

    sound_decode decode_i (
        .clk(clk), .rst_n(rst_n), .bus(bus_i.decoder),
        .m2s(m2s), .m2s_set(m2s_set), .s2m(s2m), .nmi_n(nmi_n),
        .psg0_cs(psg0_cs), .psg1_cs(psg1_cs),
        .psg0_rdata(psg0_rdata), .psg1_rdata(psg1_rdata),
        .pcm_set(pcm_set), .pcm_en(pcm_en), .gain(gain), .st_dout(st_dout)
    );

    // psg0 ports hold the sample start address
    psg psg0_i (
        .clk(clk), .rst_n(rst_n), .cen(cen_psg), .bus(bus_i.peripheral),
        .cs(psg0_cs), .rdata(psg0_rdata), .ioa_in(8'h00), .iob_in(8'h00),
        .ioa_out(smp_lo), .iob_out(smp_hi), .sound(psg0)
    );

    // psg1 reads back the play position, pulled-up bits set
    psg psg1_i (
        .clk(clk), .rst_n(rst_n), .cen(cen_psg), .bus(bus_i.peripheral),
        .cs(psg1_cs), .rdata(psg1_rdata),
        .ioa_in({pcm_addr[7:1], 1'b1}), .iob_in({1'b1, pcm_addr[14:8]}),
        .ioa_out(), .iob_out(), .sound(psg1)
    );

    adpcm_decoder adpcm_i (
        .clk(clk), .rst_n(rst_n), .cen(cen_pcm), .en(pcm_en),
        .nibble(nibble), .vclk(vclk), .sample(pcm_raw)
    );

    pcm_player player_i (
        .clk(clk), .rst_n(rst_n), .pcm_set(pcm_set), .pcm_en(pcm_en),
        .start_addr({smp_hi, smp_lo}), .gain(gain), .vclk(vclk), .sample(pcm_raw),
        .pcm_data(pcm_data), .pcm_ok(pcm_ok), .pcm_addr(pcm_addr),
        .nibble(nibble), .pcm(pcm)
    );

endmodule

/* src/pcm_player.sv */
// sample ROM player and gain
module pcm_player (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 pcm_set,
    input  logic                 pcm_en,
    input  logic [15:0]          start_addr,
    input  logic [3:0]           gain,
    input  logic                 vclk,
    input  sound_pkg::sample_t   sample,
    input  logic [7:0]           pcm_data,
    input  logic                 pcm_ok,
    output sound_pkg::pcm_addr_t pcm_addr,
    output logic [3:0]           nibble,
    output sound_pkg::sample_t   pcm
);

    logic               nibble_sel;  // low nibble second
    logic signed [5:0]  gain_mul;
    logic signed [16:0] scaled;

    // gain of 1..16 sixteenths
    assign gain_mul = $signed({2'b00, gain} + 6'd1);
    assign scaled   = sample * gain_mul;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pcm_addr   <= '0;
            nibble_sel <= 1'b0;
        end else if (pcm_set) begin
            pcm_addr   <= start_addr[14:0];  // top bit not wired on the board
            nibble_sel <= 1'b0;
        end else if (!pcm_en) begin
            nibble_sel <= 1'b0;
        end else if (vclk) begin
            {pcm_addr, nibble_sel} <= {pcm_addr, nibble_sel} + 16'd1;
        end
    end

    // keeps the last nibble while the ROM is busy
    always_ff @(posedge clk) begin
        if (pcm_ok) begin
            nibble <= nibble_sel ? pcm_data[3:0] : pcm_data[7:4];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pcm <= '0;
        end else begin
            pcm <= sound_pkg::sample_t'(scaled >>> 4);
        end
    end

endmodule

/* src/adpcm_decoder.sv */
// OKI ADPCM decoder
module adpcm_decoder (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cen,
    input  logic               en,
    input  logic [3:0]         nibble,
    output logic               vclk,
    output sound_pkg::sample_t sample
);

    logic [$clog2(sound_pkg::pcm_div)-1:0] div_cnt;
    logic [5:0]                            index;
    logic [10:0]                           step;
    logic [12:0]                           diff;
    logic signed [13:0]                    diff_s;
    logic signed [13:0]                    sum;
    logic signed [6:0]                     index_sum;
    logic [5:0]                            index_nx;
    sound_pkg::sample_t                    signal;
    sound_pkg::sample_t                    signal_nx;

    // last pulse of each group
    assign vclk = en & cen & (int'(div_cnt) == sound_pkg::pcm_div - 1);
    assign step = sound_pkg::adpcm_step[index];

    always_comb begin
        diff = 13'(step >> 3);
        if (nibble[2]) diff = diff + 13'(step);
        if (nibble[1]) diff = diff + 13'(step >> 1);
        if (nibble[0]) diff = diff + 13'(step >> 2);
    end

    assign diff_s = $signed({1'b0, diff});
    assign sum    = nibble[3] ? signal - diff_s : signal + diff_s;

    // clip to 12 bits
    always_comb begin
        if (sum > 14'sd2047) begin
            signal_nx = 12'sd2047;
        end else if (sum < -14'sd2048) begin
            signal_nx = -12'sd2048;
        end else begin
            signal_nx = sum[11:0];
        end
    end

    assign index_sum = $signed({1'b0, index}) + sound_pkg::adpcm_index_delta[nibble[2:0]];

    always_comb begin
        if (index_sum < 7'sd0) begin
            index_nx = 6'd0;
        end else if (index_sum > 7'sd48) begin
            index_nx = 6'd48;  // top of the step table
        end else begin
            index_nx = index_sum[5:0];
        end
    end

    // en low keeps the decoder cleared
    always_ff @(posedge clk) begin
        if (!rst_n || !en) begin
            div_cnt <= '0;
            signal  <= '0;
            index   <= 6'd0;
        end else begin
            if (cen) div_cnt <= vclk ? '0 : div_cnt + 1'b1;
            if (vclk) begin
                signal <= signal_nx;
                index  <= index_nx;
            end
        end
    end

    assign sample = signal;

endmodule

/* src/psg.sv */
// square-tone sound generator
module psg (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cen,
    cpu_bus_if.peripheral         bus,
    input  logic                  cs,
    output logic [7:0]            rdata,
    input  logic [7:0]            ioa_in,
    input  logic [7:0]            iob_in,
    output logic [7:0]            ioa_out,
    output logic [7:0]            iob_out,
    output sound_pkg::psg_level_t sound
);

    logic [3:0]          sel;
    logic [7:0]          regs [0:15];
    logic [11:0]         period [0:2];
    logic [3:0]          amp [0:2];
    logic [11:0]         cnt [0:2];
    logic [2:0]          sq;
    logic [2:0]          tone_en;
    sound_pkg::psg_reg_e reg_id;

    assign reg_id = sound_pkg::psg_reg_e'(sel);

    assign period[0] = {regs[sound_pkg::psg_tone_a_hi][3:0], regs[sound_pkg::psg_tone_a_lo]};
    assign period[1] = {regs[sound_pkg::psg_tone_b_hi][3:0], regs[sound_pkg::psg_tone_b_lo]};
    assign period[2] = {regs[sound_pkg::psg_tone_c_hi][3:0], regs[sound_pkg::psg_tone_c_lo]};

    assign amp[0] = regs[sound_pkg::psg_amp_a][3:0];
    assign amp[1] = regs[sound_pkg::psg_amp_b][3:0];
    assign amp[2] = regs[sound_pkg::psg_amp_c][3:0];

    assign tone_en = ~regs[sound_pkg::psg_mixer][2:0];  // active low enables
    assign ioa_out = regs[sound_pkg::psg_port_a];
    assign iob_out = regs[sound_pkg::psg_port_b];

    // addr[0] high writes the select latch
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sel <= 4'd0;
            for (int i = 0; i < 16; i++) begin
                regs[i] <= 8'd0;
            end
        end else if (cs && bus.wr) begin
            if (bus.addr[0]) begin
                sel <= bus.wdata[3:0];
            end else begin
                regs[sel] <= bus.wdata;
            end
        end
    end

    always_comb begin
        case (reg_id)
            sound_pkg::psg_port_a: rdata = ioa_in;  // port pins, not the latch
            sound_pkg::psg_port_b: rdata = iob_in;
            default:               rdata = regs[sel];
        endcase
        if (!(cs && bus.rd && !bus.addr[0])) begin
            rdata = 8'd0;
        end
    end

    // a zero period wraps every cen, same as one
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sq <= 3'd0;
            for (int ch = 0; ch < 3; ch++) begin
                cnt[ch] <= 12'd0;
            end
        end else if (cen) begin
            for (int ch = 0; ch < 3; ch++) begin
                if (cnt[ch] + 12'd1 >= period[ch]) begin
                    cnt[ch] <= 12'd0;
                    sq[ch]  <= ~sq[ch];
                end else begin
                    cnt[ch] <= cnt[ch] + 12'd1;
                end
            end
        end
    end

    // up to 3 x 240
    always_comb begin
        sound = '0;
        for (int ch = 0; ch < 3; ch++) begin
            if (tone_en[ch] && sq[ch]) begin
                sound = sound + {2'b00, amp[ch], 4'd0};
            end
        end
    end

endmodule

/* src/sound_decode.sv */
// sound CPU address decoder
module sound_decode (
    input  logic       clk,
    input  logic       rst_n,
    cpu_bus_if.decoder bus,
    input  logic [7:0] m2s,
    input  logic       m2s_set,
    output logic [7:0] s2m,
    output logic       nmi_n,
    output logic       psg0_cs,
    output logic       psg1_cs,
    input  logic [7:0] psg0_rdata,
    input  logic [7:0] psg1_rdata,
    output logic       pcm_set,
    output logic       pcm_en,
    output logic [3:0] gain,
    output logic [7:0] st_dout
);

    sound_pkg::region_e  region;
    sound_pkg::ctl_reg_e ctl;
    logic                mem_acc;
    logic                io_acc;
    logic                ram_we;
    logic                latch_we;
    logic                ctl_we;
    logic                nmi_clr;
    logic                m2s_set_l;
    logic [7:0]          mem_dout;
    logic [7:0]          ram [0:2**sound_pkg::ram_aw-1];

    assign region  = sound_pkg::region_e'(bus.addr[15:14]);
    assign ctl     = sound_pkg::ctl_reg_e'(bus.addr[1:0]);
    assign mem_acc = bus.mreq & (bus.wr | bus.rd);
    assign io_acc  = bus.iorq & (bus.wr | bus.rd);

    assign ram_we   = mem_acc & bus.wr & (region == sound_pkg::region_ram);
    assign latch_we = mem_acc & bus.wr & (region == sound_pkg::region_latch);
    assign ctl_we   = mem_acc & bus.wr & (region == sound_pkg::region_ctl);
    assign pcm_set  = ctl_we & (ctl == sound_pkg::ctl_pcm_set);
    assign nmi_clr  = ctl_we & (ctl == sound_pkg::ctl_nmi_clr);

    // addr[1] picks the chip
    assign psg0_cs = io_acc & ~bus.addr[1];
    assign psg1_cs = io_acc & bus.addr[1];

    assign st_dout = {pcm_en, 3'd0, gain};

    // 2 KB mirrored over the whole region
    always_ff @(posedge clk) begin
        if (ram_we) begin
            ram[bus.addr[sound_pkg::ram_aw-1:0]] <= bus.wdata;
        end
    end

    always_comb begin
        case (region)
            sound_pkg::region_ram:   mem_dout = ram[bus.addr[sound_pkg::ram_aw-1:0]];
            sound_pkg::region_latch: mem_dout = m2s;
            default:                 mem_dout = 8'd0;  // no program ROM here
        endcase
    end

    // read data holds until the next read
    always_ff @(posedge clk) begin
        if (mem_acc && bus.rd) begin
            bus.rdata <= mem_dout;
        end else if (io_acc && bus.rd) begin
            bus.rdata <= bus.addr[1] ? psg1_rdata : psg0_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s2m    <= 8'd0;
            pcm_en <= 1'b0;
            gain   <= 4'd0;
        end else begin
            if (latch_we) s2m <= bus.wdata;  // reply to main CPU
            if (ctl_we && ctl == sound_pkg::ctl_pcm_ctl) begin
                pcm_en <= bus.wdata[0];
            end
            if (ctl_we && ctl == sound_pkg::ctl_gain) begin
                gain <= bus.wdata[3:0];
            end
        end
    end

    // NMI on m2s_set rise, held until cleared by the CPU
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m2s_set_l <= 1'b0;
            nmi_n     <= 1'b1;
        end else begin
            m2s_set_l <= m2s_set;
            if (m2s_set && !m2s_set_l) begin
                nmi_n <= 1'b0;  // set beats clear
            end else if (nmi_clr) begin
                nmi_n <= 1'b1;
            end
        end
    end

endmodule

/* src/cpu_bus_if.sv */
// CPU bus bundle
interface cpu_bus_if;

    logic [15:0] addr;
    logic [7:0]  wdata;
    logic        mreq;
    logic        iorq;
    logic        wr;
    logic        rd;
    logic [7:0]  rdata;  // registered by the decoder

    modport decoder (
        input  addr,
        input  wdata,
        input  mreq,
        input  iorq,
        input  wr,
        input  rd,
        output rdata
    );

    // chips see the strobes through their own cs
    modport peripheral (
        input  addr,
        input  wdata,
        input  wr,
        input  rd
    );

endinterface

/* src/sound_pkg.sv */
// sound board definitions
package sound_pkg;

    localparam int ram_aw  = 11;  // 2 KB work RAM
    localparam int pcm_div = 4;   // cen_pcm pulses per sample

    typedef logic signed [11:0] sample_t;
    typedef logic [9:0]         psg_level_t;
    typedef logic [14:0]        pcm_addr_t;

    // memory region, addr[15:14]
    typedef enum logic [1:0] {
        region_rom,
        region_ram,
        region_ctl,
        region_latch
    } region_e;

    // control writes, addr[1:0]
    typedef enum logic [1:0] {
        ctl_pcm_set,
        ctl_pcm_ctl,
        ctl_gain,
        ctl_nmi_clr
    } ctl_reg_e;

    typedef enum logic [3:0] {
        psg_tone_a_lo = 4'd0,
        psg_tone_a_hi = 4'd1,
        psg_tone_b_lo = 4'd2,
        psg_tone_b_hi = 4'd3,
        psg_tone_c_lo = 4'd4,
        psg_tone_c_hi = 4'd5,
        psg_mixer     = 4'd7,
        psg_amp_a     = 4'd8,
        psg_amp_b     = 4'd9,
        psg_amp_c     = 4'd10,
        psg_port_a    = 4'd14,
        psg_port_b    = 4'd15
    } psg_reg_e;

    // OKI step sizes
    localparam logic [10:0] adpcm_step [0:48] = '{
        16, 17, 19, 21, 23, 25, 28, 31, 34, 37,
        41, 45, 50, 55, 60, 66, 73, 80, 88, 97,
        107, 118, 130, 143, 157, 173, 190, 209, 230, 253,
        279, 307, 337, 371, 408, 449, 494, 544, 598, 658,
        724, 796, 876, 963, 1060, 1166, 1282, 1411, 1552
    };

    localparam logic signed [4:0] adpcm_index_delta [0:7] = '{
        -1, -1, -1, -1, 2, 4, 6, 8
    };

endpackage
